// ==== flist.f ====
hw/soc_pkg.sv
hw/wb_addr_decoder.sv
hw/boot_rom.sv
hw/l2_spm.sv
hw/clint_timer.sv
hw/debug_req_gate.sv
hw/soc_subsystem.sv
verification/tb_soc_subsystem.sv

// ==== hw/boot_rom.sv ====
// ----------------------------------------
// Boot ROM, registered read and ack
// Words past the image read zero
// Writes are acked and dropped
// ----------------------------------------
`timescale 1ns/1ps

module boot_rom
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int unsigned IdxWidth = $clog2(BootImageWords);

  logic                 access;
  logic [AddrWidth-3:0] word_idx;
  logic                 ack_q;
  logic [DataWidth-1:0] rdata_q;

  assign access   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign word_idx = wb_req_i.adr[AddrWidth-1:2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (word_idx < BootImageWords) begin
        rdata_q <= BootImage[word_idx[IdxWidth-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

endmodule

// ==== hw/clint_timer.sv ====
// ----------------------------------------
// CLINT for one hart, 32-bit register halves
// mtime counts every second rtc_i rising edge
// rtc_i is async, up to 3 cycles of jitter
// ----------------------------------------
`timescale 1ns/1ps

module clint_timer
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  logic    rtc_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    timer_irq_o,
  output logic    ipi_o
);

  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 rtc_div_q;
  logic                 rtc_rise;
  logic                 tick;
  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic                 msip_q;
  logic                 access;
  logic                 wr_en;
  logic                 ack_q;
  logic [DataWidth-1:0] rdata;
  logic [DataWidth-1:0] rdata_q;

  // ----------------------------------------
  // Time base
  // ----------------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // Every other edge
  assign tick     = rtc_rise & rtc_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_en  = access & wb_req_i.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q      <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      ack_q <= access;
      if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      // Bus write wins over the tick for the half it touches
      if (wr_en) begin
        case (wb_req_i.adr)
          ClintMsipOff: begin
            if (wb_req_i.sel[0]) begin
              msip_q <= wb_req_i.dat[0];
            end
          end
          ClintMtimecmpLoOff: begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], wb_req_i.dat, wb_req_i.sel);
          end
          ClintMtimecmpHiOff: begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wb_req_i.dat, wb_req_i.sel);
          end
          ClintMtimeLoOff: begin
            mtime_q[31:0] <= merge_bytes(mtime_q[31:0], wb_req_i.dat, wb_req_i.sel);
          end
          ClintMtimeHiOff: begin
            mtime_q[63:32] <= merge_bytes(mtime_q[63:32], wb_req_i.dat, wb_req_i.sel);
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (wb_req_i.adr)
      ClintMsipOff:       rdata = {{(DataWidth-1){1'b0}}, msip_q};
      ClintMtimecmpLoOff: rdata = mtimecmp_q[31:0];
      ClintMtimecmpHiOff: rdata = mtimecmp_q[63:32];
      ClintMtimeLoOff:    rdata = mtime_q[31:0];
      ClintMtimeHiOff:    rdata = mtime_q[63:32];
      default:            rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

// ==== hw/debug_req_gate.sv ====
// ----------------------------------------
// Holds off debug requests after reset
// so that boot code runs first
// ----------------------------------------
`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;

  // Counts down once, then stays at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(DbgDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

// ==== hw/l2_spm.sv ====
// ----------------------------------------
// L2 scratchpad, byte-select writes
// SpmWords must be a power of two
// Word address wraps modulo SpmWords
// ----------------------------------------
`timescale 1ns/1ps

module l2_spm
  import soc_pkg::*;
#(
  parameter int unsigned SpmWords = 4096
) (
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int unsigned IdxWidth = $clog2(SpmWords);

  logic [DataWidth-1:0] mem [SpmWords];
  logic [IdxWidth-1:0]  word_idx;
  logic                 access;
  logic                 ack_q;
  logic [DataWidth-1:0] rdata_q;

  assign access   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign word_idx = wb_req_i.adr[IdxWidth+1:2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array and read data
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (wb_req_i.we) begin
        mem[word_idx] <= merge_bytes(mem[word_idx], wb_req_i.dat, wb_req_i.sel);
      end
      rdata_q <= mem[word_idx];
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

endmodule

// ==== hw/soc_pkg.sv ====
// ----------------------------------------
// Shared types and constants of the subsystem
// Wishbone classic, 32-bit address and data
// Address ranges are half-open [base, base + length)
// ----------------------------------------

package soc_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  // Master to target, 71 bits
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [SelWidth-1:0]  sel;
    logic [DataWidth-1:0] dat;
  } wb_req_t;

  // Target to master, 34 bits
  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    TargetRom,
    TargetSpm,
    TargetClint,
    TargetNone
  } target_e;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] SpmBase     = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] SpmLength   = 32'h0000_4000;

  // CLINT register offsets
  localparam logic [AddrWidth-1:0] ClintMsipOff       = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] ClintMtimecmpLoOff = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] ClintMtimecmpHiOff = 32'h0000_4004;
  localparam logic [AddrWidth-1:0] ClintMtimeLoOff    = 32'h0000_BFF8;
  localparam logic [AddrWidth-1:0] ClintMtimeHiOff    = 32'h0000_BFFC;

  // Boot image, jumps to the address stored in word 6
  localparam int unsigned BootImageWords = 8;
  localparam logic [0:BootImageWords-1][DataWidth-1:0] BootImage = '{
    32'h0000_0297,
    32'h0202_8593,
    32'hF140_2573,
    32'h0182_A283,
    32'h0002_8067,
    32'h0000_0013,
    32'h1000_0000,
    32'h0000_0000
  };

  // Byte-lane merge under a select mask
  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_w,
                                                       input logic [DataWidth-1:0] new_w,
                                                       input logic [SelWidth-1:0]  sel);
    logic [DataWidth-1:0] res;
    res = old_w;
    for (int b = 0; b < SelWidth; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== hw/soc_subsystem.sv ====
// ----------------------------------------
// Memory-mapped backbone, one hart
// Single Wishbone master, fixed 1-cycle ack
// rtc_i may be asynchronous to clk_i
// ----------------------------------------
`timescale 1ns/1ps

module soc_subsystem
  import soc_pkg::*;
#(
  parameter int unsigned DbgDelayCycles = 500,
  parameter int unsigned SpmWords       = 4096
) (
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  logic    rtc_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  input  logic    debug_req_i,
  output logic    debug_req_o,
  output logic    timer_irq_o,
  output logic    ipi_o
);

  wb_req_t rom_req;
  wb_req_t spm_req;
  wb_req_t clint_req;
  wb_rsp_t rom_rsp;
  wb_rsp_t spm_rsp;
  wb_rsp_t clint_rsp;

  wb_addr_decoder u_wb_addr_decoder (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .wb_req_i    ( wb_req_i   ),
    .wb_rsp_o    ( wb_rsp_o   ),
    .rom_req_o   ( rom_req    ),
    .spm_req_o   ( spm_req    ),
    .clint_req_o ( clint_req  ),
    .rom_rsp_i   ( rom_rsp    ),
    .spm_rsp_i   ( spm_rsp    ),
    .clint_rsp_i ( clint_rsp  )
  );

  boot_rom u_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .wb_req_i   ( rom_req    ),
    .wb_rsp_o   ( rom_rsp    )
  );

  l2_spm #(
    .SpmWords ( SpmWords )
  ) u_l2_spm (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .wb_req_i   ( spm_req    ),
    .wb_rsp_o   ( spm_rsp    )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .wb_req_i    ( clint_req   ),
    .wb_rsp_o    ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== hw/wb_addr_decoder.sv ====
// ----------------------------------------
// Wishbone address decoder, one master
// Forwards the target-local offset
// Unmapped addresses get a one-cycle err
// ----------------------------------------
`timescale 1ns/1ps

module wb_addr_decoder
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    ndmreset_n,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output wb_req_t rom_req_o,
  output wb_req_t spm_req_o,
  output wb_req_t clint_req_o,
  input  wb_rsp_t rom_rsp_i,
  input  wb_rsp_t spm_rsp_i,
  input  wb_rsp_t clint_rsp_i
);

  target_e              tgt_sel;
  logic [AddrWidth-1:0] rom_off;
  logic [AddrWidth-1:0] spm_off;
  logic [AddrWidth-1:0] clint_off;
  logic                 err_q;

  function automatic wb_req_t route(input wb_req_t req,
                                    input logic [AddrWidth-1:0] off,
                                    input logic hit);
    wb_req_t r;
    r     = req;
    r.adr = off;
    r.cyc = req.cyc & hit;
    r.stb = req.stb & hit;
    return r;
  endfunction

  // Offsets wrap below base, so one compare covers both bounds
  assign rom_off   = wb_req_i.adr - RomBase;
  assign spm_off   = wb_req_i.adr - SpmBase;
  assign clint_off = wb_req_i.adr - ClintBase;

  always_comb begin
    if (rom_off < RomLength) begin
      tgt_sel = TargetRom;
    end else if (spm_off < SpmLength) begin
      tgt_sel = TargetSpm;
    end else if (clint_off < ClintLength) begin
      tgt_sel = TargetClint;
    end else begin
      tgt_sel = TargetNone;
    end
  end

  assign rom_req_o   = route(wb_req_i, rom_off, tgt_sel == TargetRom);
  assign spm_req_o   = route(wb_req_i, spm_off, tgt_sel == TargetSpm);
  assign clint_req_o = route(wb_req_i, clint_off, tgt_sel == TargetClint);

  // Error target for holes in the map
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wb_req_i.cyc & wb_req_i.stb & (tgt_sel == TargetNone) & ~err_q;
    end
  end

  always_comb begin
    wb_rsp_o = '0;
    case (tgt_sel)
      TargetRom:   wb_rsp_o = rom_rsp_i;
      TargetSpm:   wb_rsp_o = spm_rsp_i;
      TargetClint: wb_rsp_o = clint_rsp_i;
      default:     wb_rsp_o.err = err_q;
    endcase
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_subsystem \
  -f flist.f \
  -o tb_soc_subsystem

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_soc_subsystem

// ==== verification/tb_soc_subsystem.sv ====
// ----------------------------------------
// Testbench for the subsystem backbone
// DUT built with a 20-cycle debug hold-off
// Outputs sampled on the falling clock edge
// ----------------------------------------
`timescale 1ns/1ps

module tb_soc_subsystem
  import soc_pkg::*;
();

  localparam int unsigned DbgDelay   = 20;
  localparam int unsigned SpmWordsTb = 4096;
  localparam int unsigned AckTimeout = 16;
  localparam int unsigned IrqTimeout = 400;
  localparam int unsigned NumSpmLocs = 8;

  logic    clk_i;
  logic    ndmreset_n;
  logic    rtc_i;
  logic    debug_req_i;
  logic    debug_req_o;
  logic    timer_irq_o;
  logic    ipi_o;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int unsigned          rtc_rises;
  logic                 holdoff_done;
  logic [DataWidth-1:0] shadow [NumSpmLocs];
  logic [AddrWidth-1:0] spm_addr [NumSpmLocs];

  soc_subsystem #(
    .DbgDelayCycles ( DbgDelay   ),
    .SpmWords       ( SpmWordsTb )
  ) u_soc_subsystem (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .wb_req_i    ( wb_req      ),
    .wb_rsp_o    ( wb_rsp      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // rtc_i toggles every 7 clk_i cycles and its rising edges are counted
  initial begin
    rtc_i     = 1'b0;
    rtc_rises = 0;
    forever begin
      repeat (7) @(posedge clk_i);
      if (!rtc_i) begin
        rtc_rises <= rtc_rises + 1;
      end
      rtc_i <= ~rtc_i;
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", test, exp, act));
    end
  endtask

  // ----------------------------------------
  // Bus protocol checks
  // ----------------------------------------
  rsp_exclusive: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
                                  !(wb_rsp.ack && wb_rsp.err))
    else abort_run("ack and err were high in the same cycle");

  rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
                                  !((wb_rsp.ack || wb_rsp.err) && $past(wb_rsp.ack || wb_rsp.err)))
    else abort_run("a bus response stayed high for two cycles in a row");

  debug_stays_on: assert property (@(posedge clk_i) !holdoff_done || debug_req_o)
    else abort_run("debug_req_o dropped after the hold-off had ended");

  // One Wishbone classic cycle that drops stb at the ack edge
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdat, output logic [31:0] rdat,
                           output logic got_ack, output logic got_err);
    wb_req_t     req;
    int unsigned waited;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.sel = sel;
    req.dat = wdat;
    waited  = 0;
    @(posedge clk_i);
    wb_req <= req;
    @(negedge clk_i);
    while (!(wb_rsp.ack || wb_rsp.err) && waited < AckTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(wb_rsp.ack || wb_rsp.err)) begin
      abort_run("no ack or err came back from the bus before the timeout");
    end else begin
      rdat    = wb_rsp.dat;
      got_ack = wb_rsp.ack;
      got_err = wb_rsp.err;
      @(posedge clk_i);
      wb_req <= '0;
    end
  endtask

  task automatic wb_read(input string test, input logic [31:0] adr, input logic exp_err,
                         output logic [31:0] rdat);
    logic ack;
    logic err;
    bus_cycle(1'b0, adr, 4'hF, 32'h0, rdat, ack, err);
    check_value({test, " ack"}, 64'(!exp_err), 64'(ack));
    check_value({test, " err"}, 64'(exp_err), 64'(err));
  endtask

  task automatic wb_write(input string test, input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdat, input logic exp_err);
    logic [31:0] unused;
    logic        ack;
    logic        err;
    bus_cycle(1'b1, adr, sel, wdat, unused, ack, err);
    check_value({test, " ack"}, 64'(!exp_err), 64'(ack));
    check_value({test, " err"}, 64'(exp_err), 64'(err));
  endtask

  task automatic read_mtime(input string test, output logic [63:0] t);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(test, ClintBase + ClintMtimeLoOff, 1'b0, lo);
    wb_read(test, ClintBase + ClintMtimeHiOff, 1'b0, hi);
    t = {hi, lo};
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int unsigned idx;
    int unsigned waited;
    int unsigned r0;
    int unsigned r1;
    int          diff2;
    logic [31:0] rdat;
    logic [31:0] wdat;
    logic [31:0] exp;
    logic [3:0]  sel;
    logic [63:0] t0;
    logic [63:0] t1;

    void'($urandom(74));
    ndmreset_n   = 1'b0;
    debug_req_i  = 1'b1;
    wb_req       = '0;
    holdoff_done = 1'b0;

    repeat (8) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    for (int k = 0; k < DbgDelay + 5; k++) begin
      @(negedge clk_i);
      if (k == 0) begin
        assert (!timer_irq_o && !ipi_o) else begin
          abort_run("timer_irq_o or ipi_o was active right after reset");
        end
      end
      check_value("debug_holdoff", 64'(k >= DbgDelay), 64'(debug_req_o));
    end
    holdoff_done = 1'b1;

    // Boot ROM plus two words past the image
    for (int i = 0; i < BootImageWords + 2; i++) begin
      if (i < BootImageWords) begin
        exp = BootImage[i];
      end else begin
        exp = 32'h0;
      end
      wb_read("rom_read", RomBase + 32'(4 * i), 1'b0, rdat);
      check_value("rom_read", 64'(exp), 64'(rdat));
    end

    // One scratchpad location per 512-word slice
    for (int i = 0; i < NumSpmLocs; i++) begin
      idx         = i * 512 + ($urandom % 512);
      spm_addr[i] = SpmBase + 32'(4 * idx);
      shadow[i]   = $urandom;
      wb_write("spm_fill", spm_addr[i], 4'hF, shadow[i], 1'b0);
    end
    for (int n = 0; n < 24; n++) begin
      idx  = $urandom % NumSpmLocs;
      sel  = 4'($urandom);
      wdat = $urandom;
      wb_write("spm_partial", spm_addr[idx], sel, wdat, 1'b0);
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          shadow[idx][8*b +: 8] = wdat[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < NumSpmLocs; i++) begin
      wb_read("spm_read", spm_addr[i], 1'b0, rdat);
      check_value("spm_read", 64'(shadow[i]), 64'(rdat));
    end

    // Holes in the map
    wb_read("unmapped_read", 32'h3000_0000, 1'b1, rdat);
    check_value("unmapped_read", 64'h0, 64'(rdat));
    wb_write("unmapped_write", RomBase + RomLength, 4'hF, 32'hDEAD_BEEF, 1'b1);
    wb_read("unmapped_read", SpmBase + SpmLength, 1'b1, rdat);
    check_value("unmapped_read", 64'h0, 64'(rdat));

    // mtime rate against counted rtc edges
    read_mtime("mtime_monotonic", t0);
    read_mtime("mtime_monotonic", t1);
    assert (t1 >= t0) else begin
      abort_run($sformatf("MISMATCH mtime_monotonic expected at least 0x%0h actual 0x%0h",
                          t0, t1));
    end
    @(negedge clk_i);
    r0 = rtc_rises;
    read_mtime("mtime_rate", t0);
    repeat (700) @(posedge clk_i);
    @(negedge clk_i);
    r1 = rtc_rises;
    read_mtime("mtime_rate", t1);
    diff2 = 2 * int'(t1 - t0) - int'(r1 - r0);
    assert (t1 >= t0 && diff2 >= -2 && diff2 <= 2) else begin
      abort_run($sformatf("MISMATCH mtime_rate expected 0x%0h within one actual 0x%0h",
                          (r1 - r0) / 2, t1 - t0));
    end

    // Writing the low half of mtimecmp first keeps the compare above mtime
    read_mtime("timer_irq", t0);
    t0 = t0 + 64'd3;
    wb_write("timer_irq", ClintBase + ClintMtimecmpLoOff, 4'hF, t0[31:0], 1'b0);
    wb_write("timer_irq", ClintBase + ClintMtimecmpHiOff, 4'hF, t0[63:32], 1'b0);
    @(negedge clk_i);
    check_value("timer_irq_low", 64'h0, 64'(timer_irq_o));
    waited = 0;
    while (!timer_irq_o && waited < IrqTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    assert (timer_irq_o) else begin
      abort_run("timer_irq_o did not rise before the timeout");
    end
    wb_write("timer_irq_clear", ClintBase + ClintMtimecmpLoOff, 4'hF, 32'hFFFF_FFFF, 1'b0);
    wb_write("timer_irq_clear", ClintBase + ClintMtimecmpHiOff, 4'hF, 32'hFFFF_FFFF, 1'b0);
    @(negedge clk_i);
    check_value("timer_irq_clear", 64'h0, 64'(timer_irq_o));

    // Software interrupt
    wb_write("ipi_set", ClintBase + ClintMsipOff, 4'hF, 32'h1, 1'b0);
    @(negedge clk_i);
    check_value("ipi_set", 64'h1, 64'(ipi_o));
    wb_read("msip_read", ClintBase + ClintMsipOff, 1'b0, rdat);
    check_value("msip_read", 64'h1, 64'(rdat));
    wb_write("ipi_clear", ClintBase + ClintMsipOff, 4'hF, 32'h0, 1'b0);
    @(negedge clk_i);
    check_value("ipi_clear", 64'h0, 64'(ipi_o));

    $display("Test completed successfully");
    $finish;
  end

endmodule
